//--- Bender.yml
package:
  name: rv_mem_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/mem_bus_if.sv
      - verilog/ctrl_if.sv
      - verilog/rv_alu.sv
      - verilog/rv_lsu.sv
      - verilog/rv_core.sv
      - verilog/rv_ctrl_regs.sv
      - verilog/rv_top.sv
  - target: test
    files:
      - dv/tb_rv_top.sv

//--- dv/program_input.txt
# mem <byte addr> <word>    : memory image, loaded before reset
# end <fault pc> <retired>  : end of image, expected fault pc and retired count
# chk <name> <byte addr> <expected word>
mem 0000 00000000
mem 0048 00000000
mem 0080 00000100
mem 0084 00003ff0
mem 0200 80f17f82
mem 0204 11223344
mem 0208 55667788
mem 020c 99aabbcc
# ALU: addi, srai, srli, addi, slt, sltu, sub, write to x0
mem 0100 ff800093
mem 0104 4010d193
mem 0108 0010d213
mem 010c 00300293
mem 0110 0050a333
mem 0114 0050b3b3
mem 0118 40128433
mem 011c 00728013
# Loads from 0x200 through x9
mem 0120 20000493
mem 0124 00048503
mem 0128 00148583
mem 012c 0024c603
mem 0130 0034c683
mem 0134 00049703
mem 0138 00249783
mem 013c 0024d803
mem 0140 0004a883
# Stores: sb +5, sb +7, sh +10, sh +12, sb +14
mem 0144 005482a3
mem 0148 001483a3
mem 014c 00149523
mem 0150 00549623
mem 0154 00548723
# Branches, taken ones skip a write to x18
mem 0158 00528463
mem 015c 00100913
mem 0160 00529463
mem 0164 05500993
mem 0168 0050c463
mem 016c 00200913
mem 0170 0050e463
mem 0174 06600a13
mem 0178 0012d463
mem 017c 00300913
mem 0180 0012f463
mem 0184 07700a93
# jal, lui, auipc, jalr, then an illegal opcode
mem 0188 00800b6f
mem 018c 00400913
mem 0190 12345bb7
mem 0194 00001c17
mem 0198 018b0ce7
mem 019c 00500913
mem 01a0 00600913
mem 01a4 00000000
end 01a4 0023
chk boot_sp 0008 00003ff0
chk addi_neg 0004 fffffff8
chk srai 000c fffffffc
chk srli 0010 7ffffffc
chk slt_neg 0018 00000001
chk sltu_neg 001c 00000000
chk sub 0020 0000000b
chk x0_zero 0000 00000000
chk lb_0 0028 ffffff82
chk lb_1 002c 0000007f
chk lbu_2 0030 000000f1
chk lbu_3 0034 00000080
chk lh_0 0038 00007f82
chk lh_2 003c ffff80f1
chk lhu_2 0040 000080f1
chk lw 0044 80f17f82
chk sb_1_3 0204 f8220344
chk sh_2 0208 fff87788
chk sh_0_sb_2 020c 99030003
chk no_wrong_path 0048 00000000
chk bne_not_taken 004c 00000055
chk bltu_not_taken 0050 00000066
chk bgeu_not_taken 0054 00000077
chk jal_link 0058 0000018c
chk lui 005c 12345000
chk auipc 0060 00001194
chk jalr_link 0064 0000019c

//--- dv/tb_rv_top.sv
// Testbench for rv_top with a word memory model and random ack delays
// Loads the image and checks from dv/program_input.txt, runs until fault
`timescale 1ns/100ps
`default_nettype none

module tb_rv_top;

   logic           clk;
   logic           rst_n;
   logic           run;
   logic           mem_ack;
   rv_pkg::word_t  mem_rdata;
   logic           mem_req;
   logic           mem_we;
   rv_pkg::addr_t  mem_addr;
   rv_pkg::word_t  mem_wdata;
   rv_pkg::mask_t  mem_wmask;
   logic           fault;
   rv_pkg::addr_t  fault_pc;
   rv_pkg::count_t retired;

   logic [31:0] mem [0:16383];
   integer      seed;
   int          pass_count;
   int          fail_count;

   rv_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wmask (mem_wmask),
      .fault     (fault),
      .fault_pc  (fault_pc),
      .retired   (retired)
   );

   always #20 clk = ~clk;

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (exp === act) begin
         pass_count++;
         $display("pass: %s", name);
      end else begin
         fail_count++;
         $display("error: %s expected %08h actual %08h", name, exp, act);
      end
   endtask

   // Memory model, answers after 0 to 3 cycles
   always begin
      int delay;
      int b;
      @(posedge clk);
      #1;
      if (mem_req && !mem_ack) begin
         delay = $unsigned($random(seed)) % 4;
         repeat (delay) @(posedge clk);
         #1;
         if (mem_we) begin
            for (b = 0; b < 4; b++) begin
               if (mem_wmask[b]) begin
                  mem[mem_addr[15:2]][8*b +: 8] = mem_wdata[8*b +: 8];
               end
            end
         end
         mem_rdata = mem[mem_addr[15:2]];
         mem_ack   = 1'b1;
      end else if (!mem_req && mem_ack) begin
         mem_ack = 1'b0;
      end
   end

   initial begin
      int          fd;
      int          n;
      int          i;
      int          cycles;
      string       line;
      string       kind;
      string       name;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] exp_pc;
      logic [31:0] exp_count;
      string       chk_name [$];
      logic [15:0] chk_addr [$];
      logic [31:0] chk_data [$];

      clk        = 1'b0;
      rst_n      = 1'b0;
      run        = 1'b0;
      mem_ack    = 1'b0;
      mem_rdata  = '0;
      seed       = 32'h6a2d;
      pass_count = 0;
      fail_count = 0;
      exp_pc     = '0;
      exp_count  = '0;

      for (i = 0; i < 16384; i++) begin
         mem[i] = {i[15:0] ^ 16'ha5c3, i[15:0]};
      end

      fd = $fopen("dv/program_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the program file dv/program_input.txt");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != 8'h23) begin
               n = $sscanf(line, "%s", kind);
               if (kind == "mem") begin
                  n = $sscanf(line, "%s %h %h", kind, a, d);
                  mem[a[15:2]] = d;
               end else if (kind == "end") begin
                  n = $sscanf(line, "%s %h %h", kind, exp_pc, exp_count);
               end else if (kind == "chk") begin
                  n = $sscanf(line, "%s %s %h %h", kind, name, a, d);
                  chk_name.push_back(name);
                  chk_addr.push_back(a[15:0]);
                  chk_data.push_back(d);
               end
            end
         end
         $fclose(fd);
      end

      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b1;

      cycles = 0;
      while (!fault && cycles < 20000) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!fault) begin
         $display("timeout: the core never reached the fault state");
         fail_count++;
      end else begin
         // Let the retired count settle
         repeat (2) @(posedge clk);
         #1;

         for (i = 0; i < chk_name.size(); i++) begin
            compare_value(chk_name[i], chk_data[i], mem[chk_addr[i][15:2]]);
         end
         compare_value("fault_pc", exp_pc, {16'd0, fault_pc});
         compare_value("retired", exp_count, {16'd0, retired});
      end

      $display("tests: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/mem_bus_if.sv
verilog/ctrl_if.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
verilog/rv_ctrl_regs.sv
verilog/rv_top.sv
dv/tb_rv_top.sv

//--- verilog/ctrl_if.sv
// Run enable and status signals between the control block and the core
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if;
   logic          run;
   // One-cycle pulse per completed instruction
   logic          retire;
   logic          fault;
   rv_pkg::addr_t fault_pc;

   modport regs (output run, input retire, fault, fault_pc);
   modport core (input run, output retire, fault, fault_pc);
endinterface

`default_nettype wire

//--- verilog/mem_bus_if.sv
// Word request channel from the core to the load/store unit
// Four-phase req/ack, fields held stable while req is high
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
   logic          req;
   logic          we;
   rv_pkg::addr_t addr;
   logic [1:0]    size;
   logic          unsigned_ld;
   rv_pkg::word_t wdata;
   logic          ack;
   // Already aligned and extended
   rv_pkg::word_t rdata;

   modport master (output req, we, addr, size, unsigned_ld, wdata, input ack, rdata);
   modport slave (input req, we, addr, size, unsigned_ld, wdata, output ack, rdata);
endinterface

`default_nettype wire

//--- verilog/rv_alu.sv
// Combinational RV32I ALU with branch comparison flags
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_alu (
   input  rv_pkg::word_t   a,
   input  rv_pkg::word_t   b,
   input  rv_pkg::alu_fn_t fn,
   output rv_pkg::word_t   result,
   output logic            eq,
   output logic            lt,
   output logic            ltu
);

   logic [`RV_SHAMT_W-1:0] shamt;

   assign shamt = b[`RV_SHAMT_W-1:0];
   assign eq    = (a == b);
   assign lt    = ($signed(a) < $signed(b));
   assign ltu   = (a < b);

   always_comb begin
      case (fn)
         rv_pkg::alu_sub:  result = a - b;
         rv_pkg::alu_sll:  result = a << shamt;
         rv_pkg::alu_slt:  result = {31'd0, lt};
         rv_pkg::alu_sltu: result = {31'd0, ltu};
         rv_pkg::alu_xor:  result = a ^ b;
         rv_pkg::alu_srl:  result = a >> shamt;
         rv_pkg::alu_sra:  result = rv_pkg::word_t'($signed(a) >>> shamt);
         rv_pkg::alu_or:   result = a | b;
         rv_pkg::alu_and:  result = a & b;
         default:          result = a + b;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/rv_consts.svh
// Opcode, funct3, access size and boot vector constants for the RV32I core
// Included by the core, the ALU and the load/store unit
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes
`define RV_OP_ALU_R  7'b0110011
`define RV_OP_ALU_I  7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// ALU funct3
`define RV_F3_ADD  3'h0
`define RV_F3_SLL  3'h1
`define RV_F3_SLT  3'h2
`define RV_F3_SLTU 3'h3
`define RV_F3_XOR  3'h4
`define RV_F3_SR   3'h5
`define RV_F3_OR   3'h6
`define RV_F3_AND  3'h7

// Branch funct3
`define RV_F3_BEQ  3'h0
`define RV_F3_BNE  3'h1
`define RV_F3_BLT  3'h4
`define RV_F3_BGE  3'h5
`define RV_F3_BLTU 3'h6
`define RV_F3_BGEU 3'h7

// Access sizes, same encoding as funct3[1:0] of loads and stores
`define RV_SIZE_B 2'd0
`define RV_SIZE_H 2'd1
`define RV_SIZE_W 2'd2

`define RV_SHAMT_W 5

// Boot vectors and register file placement in memory
`define RV_VEC_PC   16'h0080
`define RV_VEC_SP   16'h0084
`define RV_REG_BASE 16'h0000
`define RV_SP_REG   5'd2

`endif

//--- verilog/rv_core.sv
// Multi-cycle RV32I core, one instruction in flight
// Registers x0..x31 live in memory words 0..31, reached through the load/store unit
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_core (
   input  logic      clk,
   input  logic      rst_n,
   mem_bus_if.master bus,
   ctrl_if.core      ctrl
);

   rv_pkg::core_state_t state;
   rv_pkg::addr_t       pc;
   logic                req_q;
   logic                retire_q;
   rv_pkg::word_t       inst;
   rv_pkg::word_t       rs1_val;
   rv_pkg::word_t       rs2_val;
   rv_pkg::word_t       rd_val;

   logic [6:0]       opcode;
   logic [2:0]       funct3;
   rv_pkg::reg_idx_t rs1;
   rv_pkg::reg_idx_t rs2;
   rv_pkg::reg_idx_t rd;
   rv_pkg::word_t    imm;
   logic             mem_state;
   logic             done;
   logic             needs_rs2;
   logic             rd_zero;
   logic             taken;

   rv_pkg::word_t   alu_a;
   rv_pkg::word_t   alu_b;
   rv_pkg::alu_fn_t alu_fn;
   rv_pkg::word_t   alu_result;
   logic            alu_eq;
   logic            alu_lt;
   logic            alu_ltu;

   rv_pkg::addr_t pc_plus4;
   rv_pkg::addr_t pc_imm;
   rv_pkg::addr_t next_pc;
   rv_pkg::word_t wb_val;

   function automatic rv_pkg::addr_t reg_addr(rv_pkg::reg_idx_t idx);
      return `RV_REG_BASE + {9'd0, idx, 2'b00};
   endfunction

   function automatic rv_pkg::alu_fn_t alu_decode(logic [2:0] f3, logic alt);
      case (f3)
         `RV_F3_ADD:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
         `RV_F3_SLL:  return rv_pkg::alu_sll;
         `RV_F3_SLT:  return rv_pkg::alu_slt;
         `RV_F3_SLTU: return rv_pkg::alu_sltu;
         `RV_F3_XOR:  return rv_pkg::alu_xor;
         `RV_F3_SR:   return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
         `RV_F3_OR:   return rv_pkg::alu_or;
         default:     return rv_pkg::alu_and;
      endcase
   endfunction

   function automatic rv_pkg::core_state_t after_fetch(logic [6:0] op);
      case (op)
         `RV_OP_ALU_R, `RV_OP_ALU_I, `RV_OP_LOAD,
         `RV_OP_STORE, `RV_OP_BRANCH, `RV_OP_JALR: return rv_pkg::st_rd_rs1;
         `RV_OP_JAL, `RV_OP_LUI, `RV_OP_AUIPC:     return rv_pkg::st_exec;
         default:                                  return rv_pkg::st_fault;
      endcase
   endfunction

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign rd     = inst[11:7];
   assign rs1    = inst[19:15];
   assign rs2    = inst[24:20];

   assign needs_rs2 = (opcode == `RV_OP_ALU_R) || (opcode == `RV_OP_STORE) ||
                      (opcode == `RV_OP_BRANCH);
   assign rd_zero   = (rd == '0);
   assign mem_state = !(state inside {rv_pkg::st_exec, rv_pkg::st_fault});
   assign done      = req_q && bus.ack;

   // Immediate per format
   always_comb begin
      case (opcode)
         `RV_OP_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         `RV_OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                               inst[11:8], 1'b0};
         `RV_OP_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                               inst[30:21], 1'b0};
         `RV_OP_LUI,
         `RV_OP_AUIPC:  imm = {inst[31:12], 12'd0};
         default:       imm = {{20{inst[31]}}, inst[31:20]};
      endcase
   end

   always_comb begin
      alu_a  = rs1_val;
      alu_b  = imm;
      alu_fn = rv_pkg::alu_add;
      case (opcode)
         `RV_OP_ALU_R: begin
            alu_b  = rs2_val;
            alu_fn = alu_decode(funct3, inst[30]);
         end
         // Only shifts use bit 30 as a function bit here
         `RV_OP_ALU_I:  alu_fn = alu_decode(funct3, (funct3 == `RV_F3_SR) && inst[30]);
         `RV_OP_BRANCH: alu_b = rs2_val;
         `RV_OP_LUI:    alu_a = '0;
         `RV_OP_AUIPC:  alu_a = {16'd0, pc};
         default: ;
      endcase
   end

   rv_alu alu_i (
      .a      (alu_a),
      .b      (alu_b),
      .fn     (alu_fn),
      .result (alu_result),
      .eq     (alu_eq),
      .lt     (alu_lt),
      .ltu    (alu_ltu)
   );

   always_comb begin
      case (funct3)
         `RV_F3_BEQ:  taken = alu_eq;
         `RV_F3_BNE:  taken = !alu_eq;
         `RV_F3_BLT:  taken = alu_lt;
         `RV_F3_BGE:  taken = !alu_lt;
         `RV_F3_BLTU: taken = alu_ltu;
         `RV_F3_BGEU: taken = !alu_ltu;
         default:     taken = 1'b0;
      endcase
   end

   assign pc_plus4 = pc + 16'd4;
   assign pc_imm   = pc + imm[15:0];

   always_comb begin
      next_pc = pc_plus4;
      wb_val  = alu_result;
      case (opcode)
         `RV_OP_BRANCH: next_pc = taken ? pc_imm : pc_plus4;
         `RV_OP_JAL: begin
            next_pc = pc_imm;
            wb_val  = {16'd0, pc_plus4};
         end
         `RV_OP_JALR: begin
            next_pc = {alu_result[15:1], 1'b0};
            wb_val  = {16'd0, pc_plus4};
         end
         default: ;
      endcase
   end

   // Request fields per state
   always_comb begin
      bus.req         = req_q;
      bus.we          = 1'b0;
      bus.addr        = pc;
      bus.size        = `RV_SIZE_W;
      bus.unsigned_ld = 1'b0;
      bus.wdata       = rd_val;
      case (state)
         rv_pkg::st_boot_pc: bus.addr = `RV_VEC_PC;
         rv_pkg::st_boot_sp: bus.addr = `RV_VEC_SP;
         rv_pkg::st_boot_wsp: begin
            bus.addr = reg_addr(`RV_SP_REG);
            bus.we   = 1'b1;
         end
         rv_pkg::st_rd_rs1: bus.addr = reg_addr(rs1);
         rv_pkg::st_rd_rs2: bus.addr = reg_addr(rs2);
         rv_pkg::st_mem_acc: begin
            bus.addr        = rd_val[15:0];
            bus.we          = (opcode == `RV_OP_STORE);
            bus.size        = funct3[1:0];
            bus.unsigned_ld = funct3[2];
            bus.wdata       = rs2_val;
         end
         rv_pkg::st_wr_rd: begin
            bus.addr = reg_addr(rd);
            bus.we   = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= rv_pkg::st_boot_pc;
         pc       <= '0;
         req_q    <= 1'b0;
         retire_q <= 1'b0;
      end else begin
         retire_q <= 1'b0;
         // New request only after the previous ack has dropped
         if (mem_state && !req_q && !bus.ack && ctrl.run) begin
            req_q <= 1'b1;
         end else if (done) begin
            req_q <= 1'b0;
         end
         case (state)
            rv_pkg::st_boot_pc: if (done) begin
               pc    <= bus.rdata[15:0];
               state <= rv_pkg::st_boot_sp;
            end
            rv_pkg::st_boot_sp:  if (done) state <= rv_pkg::st_boot_wsp;
            rv_pkg::st_boot_wsp: if (done) state <= rv_pkg::st_fetch;
            rv_pkg::st_fetch:    if (done) state <= after_fetch(bus.rdata[6:0]);
            rv_pkg::st_rd_rs1: if (done) begin
               state <= needs_rs2 ? rv_pkg::st_rd_rs2 : rv_pkg::st_exec;
            end
            rv_pkg::st_rd_rs2: if (done) state <= rv_pkg::st_exec;
            rv_pkg::st_exec: if (ctrl.run) begin
               pc <= next_pc;
               if (opcode == `RV_OP_LOAD || opcode == `RV_OP_STORE) begin
                  state <= rv_pkg::st_mem_acc;
               end else if (opcode == `RV_OP_BRANCH || rd_zero) begin
                  state    <= rv_pkg::st_fetch;
                  retire_q <= 1'b1;
               end else begin
                  state <= rv_pkg::st_wr_rd;
               end
            end
            rv_pkg::st_mem_acc: if (done) begin
               if (opcode == `RV_OP_STORE || rd_zero) begin
                  state    <= rv_pkg::st_fetch;
                  retire_q <= 1'b1;
               end else begin
                  state <= rv_pkg::st_wr_rd;
               end
            end
            rv_pkg::st_wr_rd: if (done) begin
               state    <= rv_pkg::st_fetch;
               retire_q <= 1'b1;
            end
            default: state <= rv_pkg::st_fault;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (done) begin
         case (state)
            rv_pkg::st_boot_sp: rd_val <= bus.rdata;
            rv_pkg::st_fetch:   inst <= bus.rdata;
            rv_pkg::st_rd_rs1:  rs1_val <= bus.rdata;
            rv_pkg::st_rd_rs2:  rs2_val <= bus.rdata;
            rv_pkg::st_mem_acc: rd_val <= bus.rdata;
            default: ;
         endcase
      end else if (state == rv_pkg::st_exec) begin
         // Effective address for loads and stores
         rd_val <= wb_val;
      end
   end

   assign ctrl.retire   = retire_q;
   assign ctrl.fault    = (state == rv_pkg::st_fault);
   // PC is not advanced before a fault, so it still names the bad instruction
   assign ctrl.fault_pc = pc;

   a_no_x0_write : assert property (@(posedge clk) disable iff (!rst_n)
      bus.req && bus.we |-> bus.addr != '0);

endmodule

`default_nettype wire

//--- verilog/rv_ctrl_regs.sv
// Control and status block beside the core
// Holds run enable, retired instruction count and the first fault
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl_regs (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           run_in,
   ctrl_if.regs           ctrl,
   output logic           fault,
   output rv_pkg::addr_t  fault_pc,
   output rv_pkg::count_t retired
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl.run <= 1'b0;
         retired  <= '0;
         fault    <= 1'b0;
         fault_pc <= '0;
      end else begin
         ctrl.run <= run_in;
         if (ctrl.retire) begin
            retired <= retired + 16'd1;
         end
         // Sticky until reset
         if (ctrl.fault && !fault) begin
            fault    <= 1'b1;
            fault_pc <= ctrl.fault_pc;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/rv_lsu.sv
// Load/store unit between the core request channel and external memory
// Places store bytes in their lanes, extends load data, runs both handshakes
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_lsu (
   input  logic          clk,
   input  logic          rst_n,
   mem_bus_if.slave      bus,
   output logic          mem_req,
   output logic          mem_we,
   output rv_pkg::addr_t mem_addr,
   output rv_pkg::word_t mem_wdata,
   output rv_pkg::mask_t mem_wmask,
   input  logic          mem_ack,
   input  rv_pkg::word_t mem_rdata
);

   logic [1:0]    off;
   logic          start;
   rv_pkg::word_t lane_data;
   rv_pkg::mask_t lane_mask;
   rv_pkg::word_t shifted;
   rv_pkg::word_t load_val;

   assign off   = bus.addr[1:0];
   // Idle means neither side of the handshake is busy
   assign start = bus.req && !mem_req && !bus.ack;

   always_comb begin
      lane_data = bus.wdata << {off, 3'b000};
      case (bus.size)
         `RV_SIZE_B: lane_mask = rv_pkg::mask_t'(4'b0001 << off);
         `RV_SIZE_H: lane_mask = rv_pkg::mask_t'(4'b0011 << off);
         default:    lane_mask = 4'b1111;
      endcase
   end

   always_comb begin
      shifted = mem_rdata >> {off, 3'b000};
      case (bus.size)
         `RV_SIZE_B: load_val = bus.unsigned_ld ? {24'd0, shifted[7:0]} :
                                                  {{24{shifted[7]}}, shifted[7:0]};
         `RV_SIZE_H: load_val = bus.unsigned_ld ? {16'd0, shifted[15:0]} :
                                                  {{16{shifted[15]}}, shifted[15:0]};
         default:    load_val = shifted;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_req <= 1'b0;
         mem_we  <= 1'b0;
         bus.ack <= 1'b0;
      end else if (start) begin
         mem_req <= 1'b1;
         mem_we  <= bus.we;
      end else if (mem_req && mem_ack) begin
         mem_req <= 1'b0;
         bus.ack <= 1'b1;
      end else if (bus.ack && !bus.req && !mem_ack) begin
         // Both requesters have let go
         bus.ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         mem_addr  <= {bus.addr[15:2], 2'b00};
         mem_wdata <= lane_data;
         mem_wmask <= lane_mask;
      end
      if (mem_req && mem_ack) begin
         bus.rdata <= load_val;
      end
   end

   // External address must keep matching the core's held request
   a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && !mem_ack |-> mem_addr == {bus.addr[15:2], 2'b00});

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
// Shared types of the RV32I core
// Referenced by scoped names from every RTL file
`default_nettype none

package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [15:0] addr_t;
   // Bit 3 enables the most significant byte lane
   typedef logic [3:0]  mask_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [15:0] count_t;

   typedef enum logic [3:0] {
      st_boot_pc,
      st_boot_sp,
      st_boot_wsp,
      st_fetch,
      st_rd_rs1,
      st_rd_rs2,
      st_exec,
      st_mem_acc,
      st_wr_rd,
      st_fault
   } core_state_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_sll,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_srl,
      alu_sra,
      alu_or,
      alu_and
   } alu_fn_t;

endpackage

`default_nettype wire

//--- verilog/rv_top.sv
// Top level of the RV32I core with its load/store unit and control block
// Connects to one external word memory over a four-phase req/ack port
`timescale 1ns/100ps
`default_nettype none

module rv_top (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           run,
   input  logic           mem_ack,
   input  rv_pkg::word_t  mem_rdata,
   output logic           mem_req,
   output logic           mem_we,
   output rv_pkg::addr_t  mem_addr,
   output rv_pkg::word_t  mem_wdata,
   output rv_pkg::mask_t  mem_wmask,
   output logic           fault,
   output rv_pkg::addr_t  fault_pc,
   output rv_pkg::count_t retired
);

   mem_bus_if bus_if ();
   ctrl_if    ctrl ();

   rv_core core_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus_if.master),
      .ctrl  (ctrl.core)
   );

   rv_lsu lsu_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus       (bus_if.slave),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wmask (mem_wmask),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   rv_ctrl_regs regs_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .run_in   (run),
      .ctrl     (ctrl.regs),
      .fault    (fault),
      .fault_pc (fault_pc),
      .retired  (retired)
   );

endmodule

`default_nettype wire
